/* spi_mbox_pkg.sv */
// Shared widths, register map and mailbox reset image for the SPI mailbox loopback
package spi_mbox_pkg;

	// ************************************************************
	// Payload and mailbox geometry
	// ************************************************************

	// Every payload on the link is one byte
	localparam int data_w = 8;

	// Mailbox slot count and matching pointer width
	localparam int mbox_depth = 8;
	localparam int ptr_w = 3;

	// ************************************************************
	// SCK timing
	// ************************************************************

	// Half-period divider register width
	localparam int div_w = 8;

	// Floor on the divider
	// Four system clocks per SCK half period cover the slave synchronizer and reply
	localparam logic [div_w-1:0] div_min = 8'd3;

	// ************************************************************
	// Host register map
	// ************************************************************

	localparam int addr_w = 2;

	// Divider, read and write
	localparam logic [addr_w-1:0] reg_div = 2'd0;
	// Transmit byte, a write launches a transfer
	localparam logic [addr_w-1:0] reg_tx = 2'd1;
	// Last received byte, read only
	localparam logic [addr_w-1:0] reg_rx = 2'd2;
	// Status, bit 0 is busy, read only
	localparam logic [addr_w-1:0] reg_status = 2'd3;

	// Mailbox contents after reset
	// Slot i holds (i+1) times 0x11, slot 0 sits in the low byte
	localparam logic [mbox_depth-1:0][data_w-1:0] mbox_init = {
		8'h88,
		8'h77,
		8'h66,
		8'h55,
		8'h44,
		8'h33,
		8'h22,
		8'h11
	};

endpackage

/* spi_mbox_regs.sv */
// Host register block holding divider, transmit and receive bytes for the SPI master
module spi_mbox_regs (
	input  logic                            rvx_signal_11,
	input  logic                            csn,
	input  logic                            reg_wr,
	input  logic                            reg_rd,
	input  logic [spi_mbox_pkg::addr_w-1:0] reg_addr,
	input  logic [spi_mbox_pkg::data_w-1:0] reg_wdata,
	input  logic                            busy,
	input  logic                            done,
	input  logic [spi_mbox_pkg::data_w-1:0] rx_byte,
	output logic [spi_mbox_pkg::data_w-1:0] reg_rdata,
	output logic                            reg_rvalid,
	output logic                            start,
	output logic [spi_mbox_pkg::data_w-1:0] tx_byte,
	output logic [spi_mbox_pkg::div_w-1:0]  half_div
);
	import spi_mbox_pkg::*;

	// Last byte captured from the master
	logic [data_w-1:0] rx_q;

	// Write decodes
	logic wr_div;
	logic wr_tx;

	assign wr_div = reg_wr && (reg_addr == reg_div);
	assign wr_tx = reg_wr && (reg_addr == reg_tx);

	// ************************************************************
	// Write side
	// ************************************************************

	// Divider comes out of reset at the floor
	// Writes below the floor are raised to it
	always_ff @(posedge rvx_signal_11 or posedge csn)
	begin
		if (csn)
			half_div <= div_min;
		else if (wr_div)
			half_div <= (reg_wdata < div_min) ? div_min : reg_wdata;
	end

	// Transmit byte is stored on every write, busy or not
	always_ff @(posedge rvx_signal_11)
	begin
		if (wr_tx)
			tx_byte <= reg_wdata;
	end

	// Launch strobe, one cycle after the write
	// A strobe still in flight counts as busy, so a back to back write launches nothing
	always_ff @(posedge rvx_signal_11 or posedge csn)
	begin
		if (csn)
			start <= 1'b0;
		else
			start <= wr_tx && !busy && !start;
	end

	// Received byte arrives with the done strobe
	always_ff @(posedge rvx_signal_11)
	begin
		if (done)
			rx_q <= rx_byte;
	end

	// ************************************************************
	// Read side
	// ************************************************************

	// Read data lands one cycle after the request
	always_ff @(posedge rvx_signal_11)
	begin
		if (reg_rd)
		begin
			case (reg_addr)
				reg_div:    reg_rdata <= half_div;
				reg_tx:     reg_rdata <= tx_byte;
				reg_rx:     reg_rdata <= rx_q;
				reg_status: reg_rdata <= {{(data_w-1){1'b0}}, busy};
				default:    reg_rdata <= '0;
			endcase
		end
	end

	// Valid strobe trails the request by one cycle
	always_ff @(posedge rvx_signal_11 or posedge csn)
	begin
		if (csn)
			reg_rvalid <= 1'b0;
		else
			reg_rvalid <= reg_rd;
	end

endmodule

/* spi_master_engine.sv */
// Mode-0 SPI master that frames one byte with select, SCK and MOSI and captures MISO
module spi_master_engine (
	input  logic                            rvx_signal_11,
	input  logic                            csn,
	input  logic                            start,
	input  logic [spi_mbox_pkg::data_w-1:0] tx_byte,
	input  logic [spi_mbox_pkg::div_w-1:0]  half_div,
	output logic                            busy,
	output logic                            done,
	output logic [spi_mbox_pkg::data_w-1:0] rx_byte,
	output logic                            spi_sck,
	output logic                            spi_ss,
	output logic                            spi_mosi,
	input  logic                            spi_miso
);
	import spi_mbox_pkg::*;

	// Transfer sequence
	typedef enum logic [2:0] {
		st_idle,
		st_setup,
		st_shift,
		st_hold,
		st_done
	} state_t;

	state_t state;

	// Divider latched at launch, and position inside a half period
	logic [div_w-1:0] div_q;
	logic [div_w-1:0] half_cnt;
	logic             tick;

	// Bits already shifted out
	logic [$clog2(data_w)-1:0] bit_cnt;

	// Outgoing and incoming shifters
	logic [data_w-1:0] tx_sh;
	logic [data_w-1:0] rx_sh;

	// Last cycle of the current half period
	assign tick = (half_cnt == div_q);

	// Status straight from the state register
	// busy drops in the same cycle as done
	assign busy = (state != st_idle) && (state != st_done);
	assign done = (state == st_done);

	// ************************************************************
	// Sequencer and pin drivers
	// ************************************************************

	always_ff @(posedge rvx_signal_11 or posedge csn)
	begin
		if (csn)
		begin
			state <= st_idle;
			half_cnt <= '0;
			bit_cnt <= '0;
			spi_sck <= 1'b0;
			spi_ss <= 1'b1;
			spi_mosi <= 1'b0;
		end
		else
		begin
			// Half-period counter runs in every active state
			if (tick || (state == st_idle) || (state == st_done))
				half_cnt <= '0;
			else
				half_cnt <= half_cnt + 1'b1;

			case (state)
				st_idle:
				begin
					// Select drops and the MSB is presented ahead of the first rise
					if (start)
					begin
						state <= st_setup;
						bit_cnt <= '0;
						spi_ss <= 1'b0;
						spi_mosi <= tx_byte[data_w-1];
					end
				end
				st_setup:
				begin
					if (tick)
						state <= st_shift;
				end
				st_shift:
				begin
					if (tick)
					begin
						spi_sck <= !spi_sck;
						// Falling edge, next bit out or leave after the last
						if (spi_sck)
						begin
							if (&bit_cnt)
								state <= st_hold;
							else
							begin
								bit_cnt <= bit_cnt + 1'b1;
								spi_mosi <= tx_sh[data_w-2];
							end
						end
					end
				end
				st_hold:
				begin
					// Deselect at the end of the hold half period
					if (tick)
					begin
						state <= st_done;
						spi_ss <= 1'b1;
						spi_mosi <= 1'b0;
					end
				end
				default:
					state <= st_idle;
			endcase
		end
	end

	// ************************************************************
	// Data path
	// ************************************************************

	always_ff @(posedge rvx_signal_11)
	begin
		if ((state == st_idle) && start)
		begin
			tx_sh <= tx_byte;
			div_q <= half_div;
		end
		else if ((state == st_shift) && tick)
		begin
			// MISO sampled as SCK rises, transmit shifter advances as it falls
			if (!spi_sck)
				rx_sh <= {rx_sh[data_w-2:0], spi_miso};
			else
				tx_sh <= {tx_sh[data_w-2:0], 1'b0};
		end

		// Result handed over as the transfer closes
		if ((state == st_hold) && tick)
			rx_byte <= rx_sh;
	end

endmodule

/* spi_mbox_slave.sv */
// SPI mailbox slave with an eight-byte store, replying from the slot at its pointer
module spi_mbox_slave (
	input  logic rvx_signal_11,
	input  logic csn,
	input  logic spi_sck,
	input  logic spi_ss,
	input  logic spi_mosi,
	output logic spi_miso
);
	import spi_mbox_pkg::*;

	// Two-flop synchronizers plus one delayed copy for edge detection
	logic sck_meta;
	logic sck_s;
	logic sck_d;
	logic ss_meta;
	logic ss_s;
	logic ss_d;
	logic mosi_meta;
	logic mosi_s;

	logic sck_rise;
	logic sck_fall;
	logic ss_fall;

	// Mailbox store and slot pointer
	logic [data_w-1:0] mem [mbox_depth];
	logic [ptr_w-1:0]  ptr;

	// Byte exchange state
	logic [$clog2(data_w)-1:0] bit_cnt;
	logic [data_w-1:0]         tx_sh;
	logic [data_w-1:0]         rx_sh;
	logic                      wr_pend;
	logic                      active;

	// ************************************************************
	// Pin synchronization
	// ************************************************************

	always_ff @(posedge rvx_signal_11 or posedge csn)
	begin
		if (csn)
		begin
			sck_meta <= 1'b0;
			sck_s <= 1'b0;
			sck_d <= 1'b0;
			ss_meta <= 1'b1;
			ss_s <= 1'b1;
			ss_d <= 1'b1;
			mosi_meta <= 1'b0;
			mosi_s <= 1'b0;
		end
		else
		begin
			sck_meta <= spi_sck;
			sck_s <= sck_meta;
			sck_d <= sck_s;
			ss_meta <= spi_ss;
			ss_s <= ss_meta;
			ss_d <= ss_s;
			mosi_meta <= spi_mosi;
			mosi_s <= mosi_meta;
		end
	end

	// Edges only count while selected
	assign sck_rise = sck_s && !sck_d && !ss_s;
	assign sck_fall = !sck_s && sck_d && !ss_s;
	assign ss_fall = !ss_s && ss_d;

	// ************************************************************
	// Byte exchange
	// ************************************************************

	// Bit count, commit request and output enable
	always_ff @(posedge rvx_signal_11 or posedge csn)
	begin
		if (csn)
		begin
			bit_cnt <= '0;
			wr_pend <= 1'b0;
			active <= 1'b0;
		end
		else
		begin
			wr_pend <= 1'b0;
			if (ss_s)
				active <= 1'b0;
			else if (ss_fall)
				active <= 1'b1;

			if (ss_fall)
				bit_cnt <= '0;
			else if (sck_rise)
			begin
				bit_cnt <= bit_cnt + 1'b1;
				// Eighth bit in, commit on the next edge
				if (&bit_cnt)
					wr_pend <= 1'b1;
			end
		end
	end

	// Reply loaded from the current slot, MOSI in on rise, MISO out on fall
	always_ff @(posedge rvx_signal_11)
	begin
		if (ss_fall)
			tx_sh <= mem[ptr];
		else
		begin
			if (sck_rise)
				rx_sh <= {rx_sh[data_w-2:0], mosi_s};
			if (sck_fall)
				tx_sh <= {tx_sh[data_w-2:0], 1'b0};
		end
	end

	// Store the received byte over the one just sent and step the pointer
	always_ff @(posedge rvx_signal_11 or posedge csn)
	begin
		if (csn)
		begin
			for (int i = 0; i < mbox_depth; i++)
				mem[i] <= mbox_init[i];
			ptr <= '0;
		end
		else if (wr_pend)
		begin
			mem[ptr] <= rx_sh;
			ptr <= ptr + 1'b1;  // wraps modulo 8
		end
	end

	// Low whenever deselected
	assign spi_miso = (active && !spi_ss) ? tx_sh[data_w-1] : 1'b0;

endmodule

/* spi_mbox_sys.sv */
// SPI loopback top joining the host registers, the SPI master and the mailbox slave
module spi_mbox_sys (
	input  logic                            rvx_signal_11,
	input  logic                            csn,
	input  logic                            reg_wr,
	input  logic                            reg_rd,
	input  logic [spi_mbox_pkg::addr_w-1:0] reg_addr,
	input  logic [spi_mbox_pkg::data_w-1:0] reg_wdata,
	output logic [spi_mbox_pkg::data_w-1:0] reg_rdata,
	output logic                            reg_rvalid,
	output logic                            xfer_done,
	output logic                            spi_sck,
	output logic                            spi_ss,
	output logic                            spi_mosi,
	output logic                            spi_miso
);
	import spi_mbox_pkg::*;

	// Register block to master
	logic              start;
	logic [data_w-1:0] tx_byte;
	logic [div_w-1:0]  half_div;

	// Master back to register block
	logic              busy;
	logic              done;
	logic [data_w-1:0] rx_byte;

	// End of transfer marker for the host side
	assign xfer_done = done;

	// ************************************************************
	// Host registers
	// ************************************************************

	spi_mbox_regs regs_i (
		.rvx_signal_11 (rvx_signal_11),
		.csn           (csn),
		.reg_wr        (reg_wr),
		.reg_rd        (reg_rd),
		.reg_addr      (reg_addr),
		.reg_wdata     (reg_wdata),
		.busy          (busy),
		.done          (done),
		.rx_byte       (rx_byte),
		.reg_rdata     (reg_rdata),
		.reg_rvalid    (reg_rvalid),
		.start         (start),
		.tx_byte       (tx_byte),
		.half_div      (half_div)
	);

	// Master drives the pins seen at the top
	spi_master_engine master_i (
		.rvx_signal_11 (rvx_signal_11),
		.csn           (csn),
		.start         (start),
		.tx_byte       (tx_byte),
		.half_div      (half_div),
		.busy          (busy),
		.done          (done),
		.rx_byte       (rx_byte),
		.spi_sck       (spi_sck),
		.spi_ss        (spi_ss),
		.spi_mosi      (spi_mosi),
		.spi_miso      (spi_miso)
	);

	// Mailbox slave on the same clock, looped back onto the master pins
	spi_mbox_slave slave_i (
		.rvx_signal_11 (rvx_signal_11),
		.csn           (csn),
		.spi_sck       (spi_sck),
		.spi_ss        (spi_ss),
		.spi_mosi      (spi_mosi),
		.spi_miso      (spi_miso)
	);

endmodule

/* spi_mbox_sva.sv */
// Protocol assertions on the SPI master pins and the done strobe
module spi_mbox_sva (
	input logic rvx_signal_11,
	input logic csn,
	input logic spi_sck,
	input logic spi_ss,
	input logic busy,
	input logic done
);

	// ************************************************************
	// Pin protocol
	// ************************************************************

	// SCK parks low while the slave is deselected
	sck_low_when_idle: assert property (@(posedge rvx_signal_11) disable iff (csn)
		spi_ss |-> !spi_sck)
		else $error("spi_sck high while spi_ss is high");

	// ************************************************************
	// Strobes
	// ************************************************************

	// done lasts a single cycle
	done_one_cycle: assert property (@(posedge rvx_signal_11) disable iff (csn)
		done |=> !done)
		else $error("done high on two consecutive cycles");

	// busy has already dropped when done shows
	busy_low_on_done: assert property (@(posedge rvx_signal_11) disable iff (csn)
		done |-> !busy)
		else $error("busy high while done is high");

endmodule

bind spi_master_engine spi_mbox_sva sva_i (
	.rvx_signal_11 (rvx_signal_11),
	.csn           (csn),
	.spi_sck       (spi_sck),
	.spi_ss        (spi_ss),
	.busy          (busy),
	.done          (done)
);

/* tb_spi_mbox_sys.sv */
// Testbench for the SPI mailbox loopback, checking replies against a mailbox model
module tb_spi_mbox_sys;
	import spi_mbox_pkg::*;

	// DUT ports
	logic              rvx_signal_11;
	logic              csn;
	logic              reg_wr;
	logic              reg_rd;
	logic [addr_w-1:0] reg_addr;
	logic [data_w-1:0] reg_wdata;
	logic [data_w-1:0] reg_rdata;
	logic              reg_rvalid;
	logic              xfer_done;
	logic              spi_sck;
	logic              spi_ss;
	logic              spi_mosi;
	logic              spi_miso;

	// Mailbox model and stimulus state
	logic [data_w-1:0] model_mem [mbox_depth];
	logic [ptr_w-1:0]  model_ptr;
	logic [31:0]       lcg_state;
	logic [div_w-1:0]  cur_div;
	int                err_cnt;

	// Expected read results, oldest first
	bit                exp_busy_q [$];
	logic [data_w-1:0] exp_val_q [$];
	string             exp_name_q [$];

	// Entry being compared
	bit                cmp_busy;
	logic [data_w-1:0] cmp_val;
	string             cmp_name;

	// Pin capture over the current frame
	logic              sck_prev;
	logic [data_w-1:0] mosi_cap;
	logic [data_w-1:0] miso_cap;
	int                sck_rises;

	spi_mbox_sys spi_mbox_sys_i (
		.rvx_signal_11 (rvx_signal_11),
		.csn           (csn),
		.reg_wr        (reg_wr),
		.reg_rd        (reg_rd),
		.reg_addr      (reg_addr),
		.reg_wdata     (reg_wdata),
		.reg_rdata     (reg_rdata),
		.reg_rvalid    (reg_rvalid),
		.xfer_done     (xfer_done),
		.spi_sck       (spi_sck),
		.spi_ss        (spi_ss),
		.spi_mosi      (spi_mosi),
		.spi_miso      (spi_miso)
	);

	// Period of 4
	always #2 rvx_signal_11 = ~rvx_signal_11;

	// ************************************************************
	// Model and random source
	// ************************************************************

	// LCG step with the usual 32-bit constants
	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Middle bits are better mixed than the low ones
	function automatic logic [data_w-1:0] rand_byte();
		logic [31:0] r;
		r = lcg_next();
		return r[23:16];
	endfunction

	// Slot at the pointer goes back to the master, the sent byte takes its place
	function automatic logic [data_w-1:0] mailbox_exchange(input logic [data_w-1:0] sent);
		logic [data_w-1:0] old;
		old = model_mem[model_ptr];
		model_mem[model_ptr] = sent;
		model_ptr = model_ptr + 1'b1;
		return old;
	endfunction

	// ************************************************************
	// Checks
	// ************************************************************

	task automatic abort_run();
		err_cnt++;
		$display("sim failed");
		$fatal(1);
	endtask

	task automatic check_byte(input string name, input logic [data_w-1:0] expected,
		input logic [data_w-1:0] got);
		if (got !== expected)
		begin
			$display("** Error at time %0t: %s expected 0x%02h got 0x%02h",
				$time, name, expected, got);
			abort_run();
		end
	endtask

	task automatic check_busy(input string name, input logic expected, input logic got);
		if (got !== expected)
		begin
			$display("** Error at time %0t: %s expected %0b got %0b", $time, name, expected, got);
			abort_run();
		end
	endtask

	task automatic check_pin(input string name, input logic expected, input logic got);
		if (got !== expected)
		begin
			$display("** Error at time %0t: %s expected %0b got %0b", $time, name, expected, got);
			abort_run();
		end
	endtask

	task automatic check_count(input string name, input int expected, input int got);
		if (got != expected)
		begin
			$display("** Error at time %0t: %s expected %0d got %0d", $time, name, expected, got);
			abort_run();
		end
	endtask

	// Bits seen on the pins during one frame, MSB first
	task automatic check_frame(input logic [data_w-1:0] sent, input logic [data_w-1:0] reply);
		check_count("spi_sck rising edges", data_w, sck_rises);
		check_byte("spi_mosi", sent, mosi_cap);
		check_byte("spi_miso", reply, miso_cap);
	endtask

	task automatic report_timeout(input string what);
		$display("Timed out waiting for %s", what);
		abort_run();
	endtask

	// Read data is stable half a cycle after the edge that raised reg_rvalid
	always @(negedge rvx_signal_11)
	begin
		if (!csn && reg_rvalid)
		begin
			if (exp_val_q.size() == 0)
			begin
				$display("Read data came back with no read outstanding");
				abort_run();
			end
			else
			begin
				cmp_busy = exp_busy_q.pop_front();
				cmp_val = exp_val_q.pop_front();
				cmp_name = exp_name_q.pop_front();
				if (cmp_busy)
					check_busy(cmp_name, cmp_val[0], reg_rdata[0]);
				else
					check_byte(cmp_name, cmp_val, reg_rdata);
			end
		end
	end

	// Pins sampled mid-cycle, one bit each way per rising SCK while selected
	always @(negedge rvx_signal_11)
	begin
		if (!csn && spi_sck && !sck_prev && !spi_ss)
		begin
			mosi_cap = {mosi_cap[data_w-2:0], spi_mosi};
			miso_cap = {miso_cap[data_w-2:0], spi_miso};
			sck_rises++;
		end
		sck_prev = spi_sck;
	end

	// ************************************************************
	// Host bus tasks, entered and left 1 unit after a rising edge
	// ************************************************************

	task automatic write_reg(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
		reg_wr = 1'b1;
		reg_addr = addr;
		reg_wdata = data;
		@(posedge rvx_signal_11);
		#1;
		reg_wr = 1'b0;
	endtask

	// Queues the expectation, then waits for reg_rvalid
	task automatic read_reg(input logic [addr_w-1:0] addr, input bit is_busy,
		input logic [data_w-1:0] expected, input string name);
		int waited;
		exp_busy_q.push_back(is_busy);
		exp_val_q.push_back(expected);
		exp_name_q.push_back(name);
		reg_rd = 1'b1;
		reg_addr = addr;
		@(posedge rvx_signal_11);
		#1;
		reg_rd = 1'b0;
		waited = 0;
		while (!reg_rvalid)
		begin
			if (waited >= 8)
				report_timeout("reg_rvalid");
			else
			begin
				@(posedge rvx_signal_11);
				#1;
				waited++;
			end
		end
	endtask

	task automatic wait_xfer_done(input int limit);
		int waited;
		waited = 0;
		while (!xfer_done)
		begin
			if (waited >= limit)
				report_timeout("xfer_done");
			else
			begin
				@(posedge rvx_signal_11);
				#1;
				waited++;
			end
		end
	endtask

	// One byte out, then the pin frame, idle status and the returned slot
	task automatic run_transfer(input logic [data_w-1:0] tx);
		logic [data_w-1:0] expected;
		expected = mailbox_exchange(tx);
		sck_rises = 0;
		write_reg(reg_tx, tx);
		wait_xfer_done(20 * (int'(cur_div) + 1));
		check_frame(tx, expected);
		read_reg(reg_status, 1'b1, 8'h00, "busy");
		read_reg(reg_rx, 1'b0, expected, "reg_rx");
	endtask

	// Second write lands while the first is launching, only the first byte goes out
	task automatic run_double_write(input logic [data_w-1:0] first, input logic [data_w-1:0] second);
		logic [data_w-1:0] expected;
		int window;
		int seen;
		expected = mailbox_exchange(first);
		window = 20 * (int'(cur_div) + 1);
		seen = 0;
		sck_rises = 0;
		write_reg(reg_tx, first);
		write_reg(reg_tx, second);
		for (int i = 0; i < window; i++)
		begin
			if (xfer_done)
				seen++;
			@(posedge rvx_signal_11);
			#1;
		end
		if (seen == 0)
			report_timeout("xfer_done after back to back writes");
		check_count("xfer_done pulses", 1, seen);
		check_frame(first, expected);
		read_reg(reg_rx, 1'b0, expected, "reg_rx");
	endtask

	// ************************************************************
	// Stimulus
	// ************************************************************

	initial
	begin
		logic [data_w-1:0] first_b;
		logic [data_w-1:0] second_b;
		logic [div_w-1:0]  new_div;
		rvx_signal_11 = 1'b0;
		csn = 1'b1;
		reg_wr = 1'b0;
		reg_rd = 1'b0;
		reg_addr = '0;
		reg_wdata = '0;
		lcg_state = 32'h23d6;
		err_cnt = 0;
		cur_div = div_min;
		sck_prev = 1'b0;
		mosi_cap = '0;
		miso_cap = '0;
		sck_rises = 0;
		for (int i = 0; i < mbox_depth; i++)
			model_mem[i] = mbox_init[i];
		model_ptr = '0;

		repeat (5) @(posedge rvx_signal_11);
		#1;

		// Pins parked and strobes quiet in reset
		check_pin("spi_ss", 1'b1, spi_ss);
		check_pin("spi_sck", 1'b0, spi_sck);
		check_pin("spi_mosi", 1'b0, spi_mosi);
		check_pin("spi_miso", 1'b0, spi_miso);
		check_pin("xfer_done", 1'b0, xfer_done);
		check_pin("reg_rvalid", 1'b0, reg_rvalid);
		csn = 1'b0;

		// Idle and at the divider floor out of reset
		read_reg(reg_status, 1'b1, 8'h00, "busy");
		read_reg(reg_div, 1'b0, div_min, "reg_div");

		// Reset image comes back first, then the bytes sent, after the pointer wraps
		for (int n = 0; n < 16; n++)
			run_transfer(rand_byte());

		// Divider below the floor is clamped
		write_reg(reg_div, 8'd1);
		read_reg(reg_div, 1'b0, div_min, "reg_div");

		// Larger divider kept as written, range 4 to 19
		new_div = div_min + 8'd1 + (rand_byte() & 8'h0f);
		write_reg(reg_div, new_div);
		cur_div = new_div;
		read_reg(reg_div, 1'b0, new_div, "reg_div");
		for (int n = 16; n < 24; n++)
			run_transfer(rand_byte());

		first_b = rand_byte();
		second_b = rand_byte();
		run_double_write(first_b, second_b);

		// Mailbox stepped once by the double write, so the next slot answers
		run_transfer(rand_byte());

		// Let the last compare run
		@(posedge rvx_signal_11);
		#1;
		if (exp_val_q.size() != 0)
		begin
			$display("Read results still outstanding at end of run");
			err_cnt++;
		end
		if (err_cnt == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

/* spi_mbox_sys.f */
spi_mbox_pkg.sv
spi_mbox_regs.sv
spi_master_engine.sv
spi_mbox_slave.sv
spi_mbox_sys.sv
spi_mbox_sva.sv
tb_spi_mbox_sys.sv

/* run_sim.sh */
#!/bin/bash
# Builds the SPI mailbox testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_spi_mbox_sys \
	-f spi_mbox_sys.f -o tb_spi_mbox_sys_sim > build.log 2>&1 \
	|| { echo "Build failed, see build.log"; exit 1; }

./obj_dir/tb_spi_mbox_sys_sim > sim.log 2>&1

grep -q "sim failed" sim.log && { echo "Simulation FAILED, see sim.log"; exit 1; }
grep -q "sim passed" sim.log && echo "Simulation PASSED" \
	|| { echo "Simulation ended without a pass, see sim.log"; exit 1; }
